/* Makefile */
# Verilator build and run of the conversion unit testbench

TOP = fpuCvtTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -sv -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f build.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

/* build.f */
hdl/fpuFormatPkg.sv
hdl/fpuCvtPkg.sv
hdl/fpuHoldStage.sv
hdl/fpuCvtInput.sv
hdl/fpuCvtCore.sv
hdl/fpuCvtOutput.sv
hdl/fpuCvtTop.sv
dv/fpuCvtTb.sv

/* dv/fpuCvtTb.sv */
`timescale 1ns/1ps

module fpuCvtTb;

	typedef struct packed
	{
		fpuCvtPkg::cvtOpT op;
		logic [63:0] operand;
		logic [63:0] value;
		logic [31:0] stamp;	// non-held edge count at accept
	} expectT;

	localparam logic [63:0] d2iCases [16] = '{
		64'h3FE0_0000_0000_0000, 64'hBFE0_0000_0000_0000,
		64'h3FF0_0000_0000_0000, 64'hBFF0_0000_0000_0000,
		64'h3FF8_0000_0000_0000, 64'hBFF8_0000_0000_0000,
		64'h4330_0000_0000_0001, 64'h43D0_0000_0000_0000,
		64'hC3E0_0000_0000_0000, 64'h43E0_0000_0000_0000,
		64'h7FF0_0000_0000_0000, 64'hFFF0_0000_0000_0000,
		64'h7FF8_0000_0000_0000, 64'h0000_0000_0000_0001,
		64'h800F_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0000
	};

	localparam logic [63:0] i2dCases [16] = '{
		64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001,
		64'hFFFF_FFFF_FFFF_FFFF, 64'h7FFF_FFFF_FFFF_FFFF,
		64'h8000_0000_0000_0000, 64'h0000_0000_0000_0002,
		64'h0000_0000_0000_0400, 64'h0010_0000_0000_0000,
		64'h0020_0000_0000_0000, 64'h4000_0000_0000_0000,
		64'hFFFF_FF00_0000_0000, 64'h0020_0000_0000_0001,
		64'h0020_0000_0000_0003, 64'hFFDF_FFFF_FFFF_FFFF,
		64'h0040_0000_0000_0006, 64'h1234_5678_9ABC_DEF0
	};

	logic clock;
	logic rstN;
	logic exHold;
	logic opValid;
	fpuCvtPkg::cvtOpT op;
	logic [63:0] operand;
	logic resValid;
	logic [63:0] result;

	expectT expQ[$];
	int unsigned issued;
	int unsigned stallCycles;
	int unsigned cycleCount;
	int unsigned edgeCount;
	int unsigned mismatchCount;
	int unsigned otherCount;

	fpuCvtTop u_dut
	(
		.clock(clock),
		.rstN(rstN),
		.exHold(exHold),
		.opValid(opValid),
		.op(op),
		.operand(operand),
		.resValid(resValid),
		.result(result)
	);

	always #2 clock = ~clock;

	// truncate toward zero, saturate above exponent 1086
	function automatic logic [63:0] d2iRef(input logic [63:0] bits);
		logic [10:0] e;
		logic [63:0] mag;
		int p;
		e = bits[62:52];
		if (e < 11'd1023)
			return 64'd0;
		if (e > 11'd1086)
			return 64'h8000_0000_0000_0000;
		p = int'(e) - 1023;
		mag = {11'd0, 1'b1, bits[51:0]};
		if (p >= 52)
			mag = mag << (p - 52);
		else
			mag = mag >> (52 - p);
		return bits[63] ? -mag : mag;
	endfunction

	// round to nearest, ties to even
	function automatic fpuFormatPkg::doubleT i2dRef(input logic [63:0] value);
		fpuFormatPkg::doubleT d;
		logic [63:0] mag;
		logic [63:0] keep;
		logic [63:0] rem;
		logic [63:0] half;
		int msb;
		int drop;
		d = '0;
		if (value == 64'd0)
			return d;
		d.sign = value[63];
		mag = value[63] ? -value : value;	// min int reads as 2^63
		msb = 0;
		for (int i = 0; i < 64; i++)
		begin
			if (mag[i])
				msb = i;
		end
		d.exp = 11'(1023 + msb);
		if (msb <= 52)
		begin
			keep = mag << (52 - msb);	// exact
		end
		else
		begin
			drop = msb - 52;
			keep = mag >> drop;
			rem = mag & ((64'd1 << drop) - 64'd1);
			half = 64'd1 << (drop - 1);
			if (rem > half || (rem == half && keep[0]))
				keep = keep + 64'd1;
			if (keep[53])
			begin
				keep = keep >> 1;	// carried into the next binade
				d.exp = d.exp + 11'd1;
			end
		end
		d.frac = keep[51:0];
		return d;
	endfunction

	function automatic logic [63:0] randomDouble();
		logic [63:0] bits;
		bits = {$urandom(), $urandom()};
		bits[62:52] = 11'(1000 + $urandom_range(100));	// around the int range edges
		return bits;
	endfunction

	function automatic logic [63:0] randomInt();
		logic [63:0] bits;
		bits = {$urandom(), $urandom()};
		return $signed(bits) >>> $urandom_range(63);	// spread leading zeros
	endfunction

	task automatic checkInt(input logic [63:0] got, input logic [63:0] exp,
		input logic [63:0] src);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("mismatch at %0t ns: D2I of %h gave %h, expected %h",
				$time, src, got, exp);
		end
	endtask

	task automatic checkDouble(input fpuFormatPkg::doubleT got,
		input fpuFormatPkg::doubleT exp, input logic [63:0] src);
		if (got !== exp)
		begin
			mismatchCount++;
			$write("mismatch at %0t ns: I2D of %h gave sign %b exp %h frac %h",
				$time, src, got.sign, got.exp, got.frac);
			$display(", expected sign %b exp %h frac %h",
				exp.sign, exp.exp, exp.frac);
		end
	endtask

	// reference functions against values worked out by hand
	task automatic checkReference();
		checkInt(d2iRef(64'hBFF8_0000_0000_0000), 64'hFFFF_FFFF_FFFF_FFFF,
			64'hBFF8_0000_0000_0000);
		checkInt(d2iRef(64'h4330_0000_0000_0001), 64'h0010_0000_0000_0001,
			64'h4330_0000_0000_0001);
		checkInt(d2iRef(64'h7FF8_0000_0000_0000), 64'h8000_0000_0000_0000,
			64'h7FF8_0000_0000_0000);
		checkDouble(i2dRef(64'h0020_0000_0000_0001), 64'h4340_0000_0000_0000,
			64'h0020_0000_0000_0001);
		checkDouble(i2dRef(64'h0020_0000_0000_0003), 64'h4340_0000_0000_0002,
			64'h0020_0000_0000_0003);
		checkDouble(i2dRef(64'h7FFF_FFFF_FFFF_FFFF), 64'h43E0_0000_0000_0000,
			64'h7FFF_FFFF_FFFF_FFFF);
		checkDouble(i2dRef(64'hFFFF_FFFF_FFFF_FFFF), 64'hBFF0_0000_0000_0000,
			64'hFFFF_FFFF_FFFF_FFFF);
	endtask

	// idle after reset, outputs must stay cleared
	task automatic checkIdle(input int unsigned cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			opValid = 1'b0;
			exHold = 1'b0;
			stallCycles++;
			if (resValid !== 1'b0 || result !== 64'd0)
			begin
				mismatchCount++;
				$display("mismatch at %0t ns: idle resValid %b result %h, expected 0 and 0",
					$time, resValid, result);
			end
		end
	endtask

	task automatic sendOp(input fpuCvtPkg::cvtOpT nextOp, input logic [63:0] value,
		input bit withHold);
		int unsigned gap;
		int unsigned stretch;
		gap = 0;
		stretch = 0;
		if (withHold && $urandom_range(4) == 0)
			gap = $urandom_range(2, 1);
		if (withHold && $urandom_range(3) == 0)
			stretch = $urandom_range(4, 1);
		repeat (gap)
		begin
			@(negedge clock);
			opValid = 1'b0;
			exHold = ($urandom_range(1) == 1);
			stallCycles++;
		end
		repeat (stretch)
		begin
			@(negedge clock);
			opValid = 1'b1;	// presented but frozen
			op = nextOp;
			operand = value;
			exHold = 1'b1;
			stallCycles++;
		end
		@(negedge clock);
		opValid = 1'b1;
		op = nextOp;
		operand = value;
		exHold = 1'b0;
		issued++;
	endtask

	// scoreboard, consumes at non-held edges only
	always @(posedge clock)
	begin : scoreboard
		expectT entry;
		if (rstN && !exHold)
		begin
			if (resValid)
			begin
				if (expQ.size() == 0)
				begin
					otherCount++;
					$display("%0t ns: resValid is high but no operation is outstanding", $time);
				end
				else
				begin
					entry = expQ.pop_front();
					if (edgeCount - entry.stamp != 3)
					begin
						otherCount++;
						$display("%0t ns: result for %h took %0d non-held edges instead of 3",
							$time, entry.operand, edgeCount - entry.stamp);
					end
					if (entry.op == fpuCvtPkg::opD2I)
						checkInt(result, entry.value, entry.operand);
					else
						checkDouble(result, entry.value, entry.operand);
				end
			end
			if (opValid)
			begin
				entry.op = op;
				entry.operand = operand;
				entry.stamp = edgeCount;
				if (op == fpuCvtPkg::opD2I)
					entry.value = d2iRef(operand);
				else
					entry.value = i2dRef(operand);
				expQ.push_back(entry);
			end
			edgeCount++;
		end
	end

	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount > 2 * issued + stallCycles + 100)
		begin
			$display("timeout after %0d cycles with %0d results outstanding",
				cycleCount, expQ.size());
			$display("Test failed");
			$finish;
		end
	end

	initial
	begin : stimulus
		int unsigned drainCycles;
		clock = 1'b0;
		rstN = 1'b0;
		exHold = 1'b0;
		opValid = 1'b0;
		op = fpuCvtPkg::opD2I;
		operand = '0;
		issued = 0;
		stallCycles = 0;
		cycleCount = 0;
		edgeCount = 0;
		mismatchCount = 0;
		otherCount = 0;
		void'($urandom(32'h8ab8_d0c9));

		repeat (10) @(negedge clock);
		rstN = 1'b1;
		checkIdle(4);
		checkReference();

		foreach (d2iCases[i])
			sendOp(fpuCvtPkg::opD2I, d2iCases[i], 1'b0);
		repeat (200)
			sendOp(fpuCvtPkg::opD2I, randomDouble(), 1'b0);

		foreach (i2dCases[i])
			sendOp(fpuCvtPkg::opI2D, i2dCases[i], 1'b0);
		repeat (200)
			sendOp(fpuCvtPkg::opI2D, randomInt(), 1'b0);

		// mixed traffic with exHold stretches
		repeat (400)
		begin
			if ($urandom_range(1) == 0)
				sendOp(fpuCvtPkg::opD2I, randomDouble(), 1'b1);
			else
				sendOp(fpuCvtPkg::opI2D, randomInt(), 1'b1);
		end

		drainCycles = 0;
		while (expQ.size() != 0 && drainCycles < 20)
		begin
			@(negedge clock);
			opValid = 1'b0;
			exHold = 1'b0;
			drainCycles++;
			stallCycles++;
		end
		if (expQ.size() != 0)
		begin
			otherCount += expQ.size();
			$display("%0d results never came out of the pipeline", expQ.size());
		end

		$display("%0d operations, %0d mismatches, %0d other errors",
			issued, mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* hdl/fpuCvtCore.sv */
`timescale 1ns/1ps

module fpuCvtCore
(
	input fpuCvtPkg::decodeT stageIn,
	output fpuCvtPkg::coreT stageOut
);

	localparam int unsigned dropBits = fpuFormatPkg::intWidth - fpuFormatPkg::sigWidth;

	logic [fpuFormatPkg::intWidth-1:0] normalized;
	logic [fpuFormatPkg::sigWidth-1:0] truncSig;
	logic guardBit;
	logic stickyBit;
	logic roundUp;
	logic [fpuFormatPkg::sigWidth:0] roundedSig;
	logic [fpuFormatPkg::expWidth-1:0] baseExp;

	// I2D: msb moves to bit 63
	assign normalized = stageIn.mag << stageIn.shift;
	assign truncSig = normalized[fpuFormatPkg::intWidth-1 -: fpuFormatPkg::sigWidth];
	assign guardBit = normalized[dropBits-1];
	assign stickyBit = |normalized[dropBits-2:0];
	assign roundUp = guardBit & (stickyBit | truncSig[0]);	// ties go to even
	assign roundedSig = {1'b0, truncSig} + {{fpuFormatPkg::sigWidth{1'b0}}, roundUp};

	// 2^63 has biased exponent 1086
	assign baseExp = fpuFormatPkg::expMaxInt
		- {{(fpuFormatPkg::expWidth - fpuCvtPkg::shiftWidth){1'b0}}, stageIn.shift};

	always_comb
	begin
		stageOut = '0;
		stageOut.op = stageIn.op;
		stageOut.sign = stageIn.sign;
		stageOut.zero = stageIn.zero;
		stageOut.overflow = stageIn.overflow;
		if (stageIn.op == fpuCvtPkg::opD2I)
		begin
			stageOut.intMag = stageIn.mag >> stageIn.shift;	// truncates toward zero
		end
		else if (roundedSig[fpuFormatPkg::sigWidth])
		begin
			// significand wrapped to 2.0
			stageOut.exp = baseExp + 1'b1;
			stageOut.sig = roundedSig[fpuFormatPkg::sigWidth:1];
		end
		else
		begin
			stageOut.exp = baseExp;
			stageOut.sig = roundedSig[fpuFormatPkg::sigWidth-1:0];
		end

		// range promised by the decode in the input side
		if (stageIn.op == fpuCvtPkg::opD2I && !stageIn.zero && !stageIn.overflow)
			assert (stageIn.shift < fpuCvtPkg::shiftT'(fpuFormatPkg::intWidth))
				else $error("D2I shift count %0d out of range", stageIn.shift);
	end

endmodule

/* hdl/fpuCvtInput.sv */
`timescale 1ns/1ps

module fpuCvtInput
(
	input fpuCvtPkg::cvtOpT op,
	input logic [fpuFormatPkg::intWidth-1:0] operand,
	output fpuCvtPkg::decodeT decoded
);

	fpuFormatPkg::doubleT dbl;
	logic intNeg;
	logic [fpuFormatPkg::intWidth-1:0] absValue;
	logic [fpuFormatPkg::expWidth-1:0] shiftWide;

	// priority search from the top bit down
	function automatic fpuCvtPkg::shiftT leadingZeros(
		input logic [fpuFormatPkg::intWidth-1:0] value);
		fpuCvtPkg::shiftT count;
		count = fpuCvtPkg::shiftT'(fpuFormatPkg::intWidth);
		for (int i = 0; i < fpuFormatPkg::intWidth; i++)
		begin
			if (value[i])
				count = fpuCvtPkg::shiftT'(fpuFormatPkg::intWidth - 1 - i);
		end
		return count;
	endfunction

	assign dbl = operand;
	assign intNeg = operand[fpuFormatPkg::intWidth-1];
	assign absValue = intNeg ? -operand : operand;	// min int stays 2^63 unsigned
	assign shiftWide = fpuFormatPkg::expMaxInt - dbl.exp;

	always_comb
	begin
		decoded = '0;
		decoded.op = op;
		if (op == fpuCvtPkg::opD2I)
		begin
			decoded.sign = dbl.sign;
			decoded.zero = dbl.exp < fpuFormatPkg::expBias;	// |x| < 1, denormals too
			decoded.overflow = dbl.exp > fpuFormatPkg::expMaxInt;	// incl. inf and NaN
			// hidden bit lands on bit 63
			decoded.mag = {1'b1, dbl.frac,
				{(fpuFormatPkg::intWidth - fpuFormatPkg::sigWidth){1'b0}}};
			if (!decoded.zero && !decoded.overflow)
				decoded.shift = fpuCvtPkg::shiftT'(shiftWide);
		end
		else
		begin
			decoded.sign = intNeg;
			decoded.zero = (operand == '0);
			decoded.overflow = 1'b0;	// every int64 fits a double
			decoded.mag = absValue;
			decoded.shift = leadingZeros(absValue);
		end
	end

endmodule

/* hdl/fpuCvtOutput.sv */
`timescale 1ns/1ps

module fpuCvtOutput
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic inValid,
	input fpuCvtPkg::coreT stageIn,
	output logic resValid,
	output logic [fpuFormatPkg::intWidth-1:0] result
);

	fpuFormatPkg::doubleT packedDbl;
	logic [fpuFormatPkg::intWidth-1:0] nextResult;

	always_comb
	begin
		packedDbl.sign = stageIn.sign;
		packedDbl.exp = stageIn.exp;
		packedDbl.frac = stageIn.sig[fpuFormatPkg::fracWidth-1:0];	// hidden bit dropped
		if (stageIn.op == fpuCvtPkg::opD2I)
		begin
			if (stageIn.zero)
				nextResult = '0;
			else if (stageIn.overflow)
				nextResult = fpuFormatPkg::intIndefinite;
			else if (stageIn.sign)
				nextResult = -stageIn.intMag;
			else
				nextResult = stageIn.intMag;
		end
		else if (stageIn.zero)
		begin
			nextResult = fpuFormatPkg::dblPosZero;	// int zero gives +0
		end
		else
		begin
			nextResult = packedDbl;
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			resValid <= 1'b0;
			result <= '0;
		end
		else if (!hold)
		begin
			resValid <= inValid;
			if (inValid)
				result <= nextResult;	// keeps last result between ops
		end
	end

	// core hands over a normalized significand
	assert property (@(posedge clock) disable iff (!rstN)
		inValid && stageIn.op == fpuCvtPkg::opI2D && !stageIn.zero
			|-> stageIn.sig[fpuFormatPkg::fracWidth])
		else $error("I2D significand reached the output side without its hidden bit");

endmodule

/* hdl/fpuCvtPkg.sv */
package fpuCvtPkg;

	// shift counts run 0..64, so one bit more than log2(64)
	localparam int unsigned shiftWidth = $clog2(fpuFormatPkg::intWidth) + 1;

	typedef logic [shiftWidth-1:0] shiftT;

	typedef enum logic
	{
		opD2I = 1'b0,	// double to int64, truncate
		opI2D = 1'b1	// int64 to double, round to nearest even
	} cvtOpT;

	// stage A: decoded operand
	typedef struct packed
	{
		cvtOpT op;
		logic sign;
		logic zero;
		logic overflow;
		logic [fpuFormatPkg::intWidth-1:0] mag;	// significand or abs value
		shiftT shift;	// right shift or leading zeros
	} decodeT;

	// stage B: shifted or normalized and rounded
	typedef struct packed
	{
		cvtOpT op;
		logic sign;
		logic zero;
		logic overflow;
		logic [fpuFormatPkg::intWidth-1:0] intMag;	// D2I only
		logic [fpuFormatPkg::expWidth-1:0] exp;	// I2D only
		logic [fpuFormatPkg::sigWidth-1:0] sig;	// I2D only, carry already in exp
	} coreT;

endpackage

/* hdl/fpuCvtTop.sv */
`timescale 1ns/1ps

module fpuCvtTop
(
	input logic clock,
	input logic rstN,
	input logic exHold,
	input logic opValid,
	input fpuCvtPkg::cvtOpT op,
	input logic [fpuFormatPkg::intWidth-1:0] operand,
	output logic resValid,
	output logic [fpuFormatPkg::intWidth-1:0] result
);

	fpuCvtPkg::decodeT decoded;
	fpuCvtPkg::decodeT stageA;
	fpuCvtPkg::coreT coreOut;
	fpuCvtPkg::coreT stageB;
	logic validA;
	logic validB;

	fpuCvtInput uInput
	(
		.op(op),
		.operand(operand),
		.decoded(decoded)
	);

	fpuHoldStage #(.payloadT(fpuCvtPkg::decodeT)) uStageA
	(
		.clock(clock),
		.rstN(rstN),
		.hold(exHold),
		.inValid(opValid),
		.inData(decoded),
		.outValid(validA),
		.outData(stageA)
	);

	fpuCvtCore uCore
	(
		.stageIn(stageA),
		.stageOut(coreOut)
	);

	fpuHoldStage #(.payloadT(fpuCvtPkg::coreT)) uStageB
	(
		.clock(clock),
		.rstN(rstN),
		.hold(exHold),
		.inValid(validA),
		.inData(coreOut),
		.outValid(validB),
		.outData(stageB)
	);

	fpuCvtOutput uOutput
	(
		.clock(clock),
		.rstN(rstN),
		.hold(exHold),
		.inValid(validB),
		.stageIn(stageB),
		.resValid(resValid),
		.result(result)
	);

endmodule

/* hdl/fpuFormatPkg.sv */
package fpuFormatPkg;

	// IEEE-754 double layout
	localparam int unsigned expWidth = 11;
	localparam int unsigned fracWidth = 52;
	localparam int unsigned sigWidth = fracWidth + 1;	// with hidden bit
	localparam int unsigned intWidth = 64;

	typedef struct packed
	{
		logic sign;
		logic [expWidth-1:0] exp;
		logic [fracWidth-1:0] frac;
	} doubleT;

	// exponent bias, also the exponent of 1.0
	localparam logic [expWidth-1:0] expBias = 11'd1023;

	// largest exponent still inside signed 64-bit range
	localparam logic [expWidth-1:0] expMaxInt = 11'd1086;

	localparam logic [expWidth-1:0] expZero = 11'd0;	// zero and denormals

	// overflow, infinity and NaN all land here
	localparam logic [intWidth-1:0] intIndefinite = 64'h8000_0000_0000_0000;

	localparam doubleT dblPosZero = '{sign: 1'b0, exp: expZero, frac: '0};

endpackage

/* hdl/fpuHoldStage.sv */
`timescale 1ns/1ps

module fpuHoldStage
#(
	parameter type payloadT = logic
)
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic inValid,
	input payloadT inData,
	output logic outValid,
	output payloadT outData
);

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			outValid <= 1'b0;
		else if (!hold)
			outValid <= inValid;
	end

	// payload only moves with a valid op
	always_ff @(posedge clock)
	begin
		if (!hold && inValid)
			outData <= inData;
	end

	assert property (@(posedge clock) disable iff (!rstN) outValid |-> !$isunknown(outData))
		else $error("hold stage carries unknown payload with valid set");

endmodule
